//--- verilog/lsu_bus_pkg.sv
////////////////////
// lsu bus types
// widths of the data bus side of the load/store unit:
// byte addresses, data words and per-lane byte enables
////////////////////

`default_nettype none

package lsu_bus_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  typedef logic [31:0] addr_t; // byte address, bus sees it word aligned
  typedef logic [31:0] data_t; // one bus / register data word

  // one enable per byte lane, lane 0 is bits 7:0
  typedef logic [3:0]  be_t;

endpackage : lsu_bus_pkg

`default_nettype wire

//--- verilog/lsu_access_pkg.sv
////////////////////
// lsu access types
// describes a single core access: where it sits in the
// word and how wide it is
////////////////////

`default_nettype none

package lsu_access_pkg;

  ////////////////////
  // access geometry
  ////////////////////

  typedef logic [1:0] byte_off_t; // address bits 1:0
  typedef logic [1:0] size_t;     // access width code

  // size codes as issued by the core decoder
  localparam size_t size_word = 2'd0; // 4 bytes
  localparam size_t size_half = 2'd1; // 2 bytes
  localparam size_t size_byte = 2'd2; // 1 byte

  // code 3 is unused, treated like a byte access

endpackage : lsu_access_pkg

`default_nettype wire

//--- verilog/lsu_req_buf.sv
////////////////////
// lsu request buffer
// holds the core request for the whole transaction,
// derives offset and split flag, keeps the first read
// word of a split load for realignment
////////////////////

`default_nettype none

module lsu_req_buf (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      req_i,        // single-cycle strobe from core
  input  wire lsu_bus_pkg::addr_t        addr_i,
  input  wire logic                      we_i,
  input  wire lsu_access_pkg::size_t     size_i,
  input  wire lsu_bus_pkg::data_t        wdata_i,
  input  wire logic                      sign_ext_i,
  input  wire logic                      first_done_i, // first part of split access done
  input  wire lsu_bus_pkg::data_t        data_rdata_i,
  output lsu_bus_pkg::addr_t             addr_o,
  output logic                           we_o,
  output lsu_access_pkg::size_t          size_o,
  output lsu_bus_pkg::data_t             wdata_o,
  output logic                           sign_ext_o,
  output lsu_access_pkg::byte_off_t      offset_o,
  output logic                           split_o,
  output lsu_bus_pkg::data_t             first_word_o
);
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;

  addr_t addr_q;
  data_t wdata_q;
  data_t first_word_q; // read data of the first part
  logic  we_q;
  size_t size_q;
  logic  sign_ext_q;

  // access context, cleared so the idle unit looks like an aligned word load
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q       <= 1'b0;
      size_q     <= size_word;
      sign_ext_q <= 1'b0;
    end else if (req_i) begin
      we_q       <= we_i;
      size_q     <= size_i;
      sign_ext_q <= sign_ext_i;
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (first_done_i) first_word_q <= data_rdata_i; // low bytes of a split load
  end

  assign offset_o = addr_q[1:0];

  // word off its boundary, or halfword crossing into the next word
  assign split_o = ((size_q == size_word) && (offset_o != 2'b00)) ||
                   ((size_q == size_half) && (offset_o == 2'b11));

  assign addr_o       = addr_q;
  assign we_o         = we_q;
  assign size_o       = size_q;
  assign wdata_o      = wdata_q;
  assign sign_ext_o   = sign_ext_q;
  assign first_word_o = first_word_q;

endmodule : lsu_req_buf

`default_nettype wire

//--- verilog/lsu_bus_seq.sv
////////////////////
// lsu bus sequencer
// runs the req/gnt/rvalid handshake for one or two parts,
// builds byte enables and lane-rotated store data,
// signals completion, errors and the last granted address
////////////////////

`default_nettype none

module lsu_bus_seq (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      req_i,      // core strobe, starts a transaction
  input  wire lsu_bus_pkg::addr_t        addr_i,     // latched request address
  input  wire logic                      we_i,
  input  wire lsu_access_pkg::size_t     size_i,
  input  wire lsu_bus_pkg::data_t        wdata_i,
  input  wire lsu_access_pkg::byte_off_t offset_i,
  input  wire logic                      split_i,
  input  wire logic                      data_gnt_i,
  input  wire logic                      data_rvalid_i,
  input  wire logic                      data_err_i,
  output logic                           data_req_o,
  output lsu_bus_pkg::addr_t             data_addr_o,
  output logic                           data_we_o,
  output lsu_bus_pkg::be_t               data_be_o,
  output lsu_bus_pkg::data_t             data_wdata_o,
  output logic                           first_done_o,
  output logic                           valid_o,
  output logic                           load_err_o,
  output logic                           store_err_o,
  output logic                           busy_o,
  output lsu_bus_pkg::addr_t             addr_last_o
);
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;

  typedef enum logic [2:0] {
    state_idle,
    state_wait_gnt,     // first (or only) part requested
    state_wait_rvalid,
    state_wait_gnt2,    // second part of a split access
    state_wait_rvalid2
  } state_e;

  state_e state_q, state_d;

  logic       second_part; // bus currently carries the second part
  logic [3:0] size_lanes;  // lanes of the access before shifting
  logic [7:0] be_wide;     // lanes over two consecutive words
  logic [63:0] wdata_dbl;
  addr_t      addr_aligned;
  addr_t      addr_next;   // next aligned word, target of part two
  addr_t      addr_last_q;

  ////////////////////
  // fsm
  ////////////////////

  always_comb begin
    state_d      = state_q;
    data_req_o   = 1'b0;
    second_part  = 1'b0;
    first_done_o = 1'b0;
    valid_o      = 1'b0;

    unique case (state_q)
      state_idle: begin
        if (req_i) state_d = state_wait_gnt; // request goes out next cycle
      end
      state_wait_gnt: begin
        data_req_o = 1'b1;
        if (data_gnt_i) state_d = state_wait_rvalid;
      end
      state_wait_rvalid: begin
        if (data_rvalid_i) begin
          if (data_err_i || !split_i) begin
            valid_o = 1'b1; // done, or first part failed and part two is dropped
            state_d = state_idle;
          end else begin
            // first part ok, second request goes out in this same cycle
            first_done_o = 1'b1;
            data_req_o   = 1'b1;
            second_part  = 1'b1;
            state_d      = data_gnt_i ? state_wait_rvalid2 : state_wait_gnt2;
          end
        end
      end
      state_wait_gnt2: begin
        data_req_o  = 1'b1;
        second_part = 1'b1;
        if (data_gnt_i) state_d = state_wait_rvalid2;
      end
      state_wait_rvalid2: begin
        if (data_rvalid_i) begin
          valid_o = 1'b1;
          state_d = state_idle;
        end
      end
      default: state_d = state_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= state_idle;
      addr_last_q <= '0;
    end else begin
      state_q <= state_d;
      if (data_req_o && data_gnt_i) begin
        // byte address of the part just granted, kept for the trap value
        addr_last_q <= second_part ? addr_next : addr_i;
      end
    end
  end

  ////////////////////
  // be and wdata
  ////////////////////

  always_comb begin
    unique case (size_i)
      size_word: size_lanes = 4'b1111;
      size_half: size_lanes = 4'b0011;
      default:   size_lanes = 4'b0001; // byte
    endcase
  end

  // low nibble is part one, spill-over into the high nibble is part two
  assign be_wide = {4'b0000, size_lanes} << offset_i;

  // rotate left by offset bytes, same lanes serve both parts
  assign wdata_dbl = {wdata_i, wdata_i} << {offset_i, 3'b000};

  assign addr_aligned = {addr_i[31:2], 2'b00};
  assign addr_next    = addr_aligned + 32'd4;

  ////////////////////
  // outputs
  ////////////////////

  assign data_addr_o  = second_part ? addr_next : addr_aligned;
  assign data_be_o    = second_part ? be_wide[7:4] : be_wide[3:0];
  assign data_wdata_o = wdata_dbl[63:32];
  assign data_we_o    = we_i;

  // error kind follows the direction of the access
  assign load_err_o  = valid_o & data_err_i & ~we_i;
  assign store_err_o = valid_o & data_err_i & we_i;

  assign busy_o      = (state_q != state_idle);
  assign addr_last_o = addr_last_q;

endmodule : lsu_bus_seq

`default_nettype wire

//--- verilog/lsu_load_align.sv
////////////////////
// lsu load aligner
// moves the loaded bytes down to bit 0, joins the two
// words of a split load, zero or sign extends
////////////////////

`default_nettype none

module lsu_load_align (
  input  wire lsu_access_pkg::size_t     size_i,
  input  wire logic                      sign_ext_i,
  input  wire lsu_access_pkg::byte_off_t offset_i,
  input  wire lsu_bus_pkg::data_t        first_word_i, // first part of a split load
  input  wire lsu_bus_pkg::data_t        data_rdata_i, // word on the bus now
  output lsu_bus_pkg::data_t             rdata_o
);
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;

  logic [63:0] joined_dbl; // current word above the first word
  logic [4:0]  shamt;      // offset in bits
  data_t       joined;     // split window, starts at the offset
  data_t       local_win;  // window inside the current word
  data_t       win;        // selected bytes at bit 0

  assign shamt      = {offset_i, 3'b000};
  assign joined_dbl = {data_rdata_i, first_word_i} >> shamt;
  assign joined     = joined_dbl[31:0];
  assign local_win  = data_rdata_i >> shamt;

  ////////////////////
  // window select
  ////////////////////

  always_comb begin
    unique case (size_i)
      size_word: begin
        win = (offset_i == 2'b00) ? data_rdata_i : joined; // any offset crosses words
      end
      size_half: begin
        win = (offset_i == 2'b11) ? joined : local_win;    // only offset 3 crosses
      end
      default: begin
        win = local_win;                                   // a byte never crosses
      end
    endcase
  end

  ////////////////////
  // extension
  ////////////////////

  always_comb begin
    unique case (size_i)
      size_word: rdata_o = win;
      size_half: rdata_o = {{16{sign_ext_i & win[15]}}, win[15:0]};
      default:   rdata_o = {{24{sign_ext_i & win[7]}}, win[7:0]};
    endcase
  end

endmodule : lsu_load_align

`default_nettype wire

//--- verilog/lsu_top.sv
////////////////////
// load/store unit top
// request buffer, bus sequencer and load aligner for a
// 32-bit core on a req/gnt/rvalid data bus
////////////////////

`default_nettype none

module lsu_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // core side
  input  wire logic                  req_i,
  input  wire lsu_bus_pkg::addr_t    addr_i,
  input  wire logic                  we_i,
  input  wire lsu_access_pkg::size_t size_i,
  input  wire lsu_bus_pkg::data_t    wdata_i,
  input  wire logic                  sign_ext_i,
  output lsu_bus_pkg::data_t         rdata_o,
  output logic                       valid_o,
  output logic                       load_err_o,
  output logic                       store_err_o,
  output logic                       busy_o,
  output lsu_bus_pkg::addr_t         addr_last_o,
  // data bus
  output logic                       data_req_o,
  input  wire logic                  data_gnt_i,
  input  wire logic                  data_rvalid_i,
  input  wire logic                  data_err_i,
  output lsu_bus_pkg::addr_t         data_addr_o,
  output logic                       data_we_o,
  output lsu_bus_pkg::be_t           data_be_o,
  output lsu_bus_pkg::data_t         data_wdata_o,
  input  wire lsu_bus_pkg::data_t    data_rdata_i
);
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;

  addr_t     buf_addr;
  logic      buf_we;
  size_t     buf_size;
  data_t     buf_wdata;
  logic      buf_sign_ext;
  byte_off_t buf_offset;
  logic      buf_split;
  data_t     buf_first_word;
  logic      first_done;

  lsu_req_buf i_req_buf (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .addr_i       (addr_i),
    .we_i         (we_i),
    .size_i       (size_i),
    .wdata_i      (wdata_i),
    .sign_ext_i   (sign_ext_i),
    .first_done_i (first_done),
    .data_rdata_i (data_rdata_i),
    .addr_o       (buf_addr),
    .we_o         (buf_we),
    .size_o       (buf_size),
    .wdata_o      (buf_wdata),
    .sign_ext_o   (buf_sign_ext),
    .offset_o     (buf_offset),
    .split_o      (buf_split),
    .first_word_o (buf_first_word)
  );

  lsu_bus_seq i_bus_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .addr_i        (buf_addr),
    .we_i          (buf_we),
    .size_i        (buf_size),
    .wdata_i       (buf_wdata),
    .offset_i      (buf_offset),
    .split_i       (buf_split),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_err_i    (data_err_i),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .first_done_o  (first_done),
    .valid_o       (valid_o),
    .load_err_o    (load_err_o),
    .store_err_o   (store_err_o),
    .busy_o        (busy_o),
    .addr_last_o   (addr_last_o)
  );

  lsu_load_align i_load_align (
    .size_i       (buf_size),
    .sign_ext_i   (buf_sign_ext),
    .offset_i     (buf_offset),
    .first_word_i (buf_first_word),
    .data_rdata_i (data_rdata_i),
    .rdata_o      (rdata_o)
  );

endmodule : lsu_top

`default_nettype wire

//--- testbench/lsu_props.sv
////////////////////
// lsu bus properties
// request/grant/rvalid protocol checks on the data bus
////////////////////

`default_nettype none

module lsu_props (
  input wire logic               clk_i,
  input wire logic               rst_ni,
  input wire logic               data_req_o,
  input wire logic               data_gnt_i,
  input wire logic               data_rvalid_i,
  input wire logic               data_err_i,
  input wire logic               data_we_o,
  input wire lsu_bus_pkg::addr_t data_addr_o,
  input wire lsu_bus_pkg::be_t   data_be_o,
  input wire lsu_bus_pkg::data_t data_wdata_o,
  input wire logic               load_err_o,
  input wire logic               store_err_o
);

  // bus only ever sees word addresses
  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_addr_o[1:0] == 2'b00))
    else $error("bus request to an unaligned address");

  // ungranted request holds address and data
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_addr_o) &&
      $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o)))
    else $error("bus request dropped or changed before grant");

  // core sees an error only in the cycle of an erroneous rvalid
  a_err_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (load_err_o || store_err_o) |-> (data_rvalid_i && data_err_i))
    else $error("core error without an erroneous rvalid");

  a_err_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_err_o && store_err_o))
    else $error("load and store error together");

endmodule : lsu_props

bind lsu_top lsu_props i_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .data_req_o    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .data_err_i    (data_err_i),
  .data_we_o     (data_we_o),
  .data_addr_o   (data_addr_o),
  .data_be_o     (data_be_o),
  .data_wdata_o  (data_wdata_o),
  .load_err_o    (load_err_o),
  .store_err_o   (store_err_o)
);

`default_nettype wire

//--- testbench/lsu_tb.sv
////////////////////
// lsu testbench
// random loads and stores from an lfsr against a 16-word
// memory responder with random grant, rvalid and error,
// checked against a byte-level reference model
////////////////////

`default_nettype none

module lsu_tb;
  import lsu_bus_pkg::*;
  import lsu_access_pkg::*;

  localparam int num_trans   = 300;
  localparam int num_aligned = 24; // first accesses are aligned loads
  localparam int wait_limit  = 64; // cycles allowed for one access

  logic  clk_i, rst_ni;
  logic  req_i, we_i, sign_ext_i;
  addr_t addr_i;
  size_t size_i;
  data_t wdata_i, rdata_o;
  logic  valid_o, load_err_o, store_err_o, busy_o;
  addr_t addr_last_o;
  logic  data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  addr_t data_addr_o;
  be_t   data_be_o;
  data_t data_wdata_o, data_rdata_i;

  logic [31:0] lfsr_q;
  data_t       mem_q [16];   // responder memory
  logic [7:0]  ref_mem [64]; // reference model, one entry per byte

  // responder state
  int    gnt_cnt, rv_cnt;
  logic  pend, pend_err, pend_we;
  addr_t pend_addr;
  be_t   pend_be;
  data_t pend_wdata;

  // granted parts, in order
  addr_t part_addr [$];
  be_t   part_be [$];
  data_t part_wdata [$];
  logic  part_we [$];
  logic  part_err [$];

  // core response seen in the valid_o cycle
  logic  valid_seen, got_lerr, got_serr;
  data_t got_rdata;
  addr_t got_last;

  int n_data_err, n_addr_err, n_be_err, n_flag_err, n_timeout;

  lsu_top i_dut (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  ////////////////////
  // helpers
  ////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [7:0] fill_byte(input logic [5:0] a);
    logic [7:0] v;
    v = {2'b00, a} * 8'd37; // odd factor, every address gets its own value
    return v + 8'h5a;
  endfunction

  function automatic data_t lane_mask(input be_t be);
    data_t m;
    for (int l = 0; l < 4; l++) m[8*l +: 8] = {8{be[l]}};
    return m;
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      n_data_err++;
      $display("[ERROR] %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      n_addr_err++;
      $display("[ERROR] %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_be(input be_t got, input be_t exp, input string what);
    if (got !== exp) begin
      n_be_err++;
      $display("[ERROR] %0t: %s got %04b expected %04b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      n_flag_err++;
      $display("[ERROR] %0t: %s got %0b expected %0b", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // one clock cycle
  ////////////////////

  // sample on the rising edge, drive the bus on the falling edge
  task automatic step_cycle();
    @(posedge clk_i);
    if (valid_o) begin
      valid_seen = 1'b1;
      got_rdata  = rdata_o;
      got_lerr   = load_err_o;
      got_serr   = store_err_o;
      got_last   = addr_last_o;
    end
    if (pend && data_rvalid_i) begin
      if (pend_we && !pend_err) begin // lanes land only on a clean response
        for (int l = 0; l < 4; l++)
          if (pend_be[l]) mem_q[pend_addr[5:2]][8*l +: 8] = pend_wdata[8*l +: 8];
      end
      pend = 1'b0;
    end else if (pend) begin
      rv_cnt--;
    end
    if (data_req_o && data_gnt_i) begin
      part_addr.push_back(data_addr_o);
      part_be.push_back(data_be_o);
      part_wdata.push_back(data_wdata_o);
      part_we.push_back(data_we_o);
      pend       = 1'b1;
      pend_addr  = data_addr_o;
      pend_be    = data_be_o;
      pend_we    = data_we_o;
      pend_wdata = data_wdata_o;
      pend_err   = (rand_bits(4) == 0); // about one part in 16
      part_err.push_back(pend_err);
      rv_cnt  = rand_bits(2) % 3;        // rvalid 1 to 3 cycles after grant
      gnt_cnt = rand_bits(2);            // grant delay of the next request
    end else if (data_req_o && gnt_cnt > 0) begin
      gnt_cnt--;
    end
    @(negedge clk_i);
    data_gnt_i    = (gnt_cnt == 0);
    data_rvalid_i = pend && (rv_cnt == 0);
    data_err_i    = pend && (rv_cnt == 0) && pend_err;
    data_rdata_i  = (pend && rv_cnt == 0) ? mem_q[pend_addr[5:2]] : '0;
  endtask

  ////////////////////
  // expected response
  ////////////////////

  task automatic check_result(input logic we, input addr_t addr, input size_t size,
                              input data_t wdata, input logic sext, input int first);
    int         nbytes, offi, lane, nparts_got, nparts_exp, nchk;
    logic       split, err1, err_exp;
    addr_t      base;
    be_t        be_exp [2];
    data_t      wd_exp [2];
    data_t      ld_exp;
    logic [5:0] ba;
    nbytes     = (size == size_word) ? 4 : (size == size_half) ? 2 : 1;
    offi       = int'(addr[1:0]);
    split      = (offi + nbytes > 4);
    base       = {addr[31:2], 2'b00};
    be_exp[0]  = '0;
    be_exp[1]  = '0;
    wd_exp[0]  = '0;
    wd_exp[1]  = '0;
    ld_exp     = '0;
    for (int k = 0; k < nbytes; k++) begin
      lane = (offi + k) % 4;
      be_exp[(offi + k < 4) ? 0 : 1][lane]            = 1'b1;
      wd_exp[(offi + k < 4) ? 0 : 1][8*lane +: 8]     = wdata[8*k +: 8];
      ba                                              = addr[5:0] + 6'(k);
      ld_exp[8*k +: 8]                                = ref_mem[ba];
    end
    nparts_got = part_addr.size() - first;
    if (nparts_got == 0) begin
      n_flag_err++;
      $display("access at %08h completed without any granted bus request", addr);
    end else begin
      err1       = part_err[first];
      nparts_exp = (split && !err1) ? 2 : 1; // first-part error drops part two
      nchk       = (nparts_got < nparts_exp) ? nparts_got : nparts_exp;
      check_flag(nparts_got == 2, nparts_exp == 2, "two bus parts");
      err_exp = 1'b0;
      for (int i = 0; i < nchk; i++) begin
        check_addr(part_addr[first + i], (i == 0) ? base : base + 32'd4, "bus address");
        check_be(part_be[first + i], be_exp[i], "bus byte enables");
        check_flag(part_we[first + i], we, "bus direction");
        if (we) begin
          check_data(part_wdata[first + i] & lane_mask(be_exp[i]), wd_exp[i],
                     "store lanes");
        end
        err_exp = err_exp | part_err[first + i];
      end
      check_flag(got_lerr, !we && err_exp, "load error");
      check_flag(got_serr, we && err_exp, "store error");
      check_addr(got_last, (nparts_exp == 2) ? base + 32'd4 : addr, "last granted address");
      if (!we && !err_exp) begin
        if (size == size_half && sext && ld_exp[15]) ld_exp[31:16] = 16'hffff;
        if (size == size_byte && sext && ld_exp[7]) ld_exp[31:8] = 24'hffffff;
        check_data(got_rdata, ld_exp, "load data");
      end
      if (we) begin // model takes the bytes of every clean part
        for (int k = 0; k < nbytes; k++) begin
          ba = addr[5:0] + 6'(k);
          if (offi + k < 4) begin
            if (!err1) ref_mem[ba] = wdata[8*k +: 8];
          end else if (nchk == 2 && !part_err[first + 1]) begin
            ref_mem[ba] = wdata[8*k +: 8];
          end
        end
      end
    end
  endtask

  task automatic run_access(input logic we, input addr_t addr, input size_t size,
                            input data_t wdata, input logic sext);
    int first, waited;
    first      = part_addr.size();
    valid_seen = 1'b0;
    req_i      = 1'b1; // single-cycle strobe
    we_i       = we;
    addr_i     = addr;
    size_i     = size;
    wdata_i    = wdata;
    sign_ext_i = sext;
    step_cycle();
    req_i  = 1'b0;
    waited = 0;
    while (!valid_seen && waited < wait_limit) begin
      step_cycle();
      waited++;
    end
    if (!valid_seen) begin
      n_timeout++;
      $display("timeout: no valid_o within %0d cycles for access at %08h", wait_limit, addr);
    end else begin
      check_result(we, addr, size, wdata, sext, first);
      check_flag(busy_o, 1'b0, "busy after valid");
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [31:0] r;
    logic        we;
    addr_t       addr;
    size_t       size;
    lfsr_q        = 32'ha875;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    size_i        = size_word;
    wdata_i       = '0;
    sign_ext_i    = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    pend          = 1'b0;
    rv_cnt        = 0;
    gnt_cnt       = rand_bits(2);
    n_data_err    = 0;
    n_addr_err    = 0;
    n_be_err      = 0;
    n_flag_err    = 0;
    n_timeout     = 0;
    for (int a = 0; a < 64; a++) ref_mem[a] = fill_byte(6'(a));
    for (int w = 0; w < 16; w++) begin
      mem_q[w] = {fill_byte(6'(4*w + 3)), fill_byte(6'(4*w + 2)),
                  fill_byte(6'(4*w + 1)), fill_byte(6'(4*w))};
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    step_cycle();
    check_flag(data_req_o, 1'b0, "data_req_o after reset");
    check_flag(valid_o, 1'b0, "valid_o after reset");
    check_flag(load_err_o, 1'b0, "load_err_o after reset");
    check_flag(store_err_o, 1'b0, "store_err_o after reset");
    check_flag(busy_o, 1'b0, "busy_o after reset");
    check_addr(addr_last_o, '0, "addr_last_o after reset");
    for (int t = 0; t < num_trans && n_timeout == 0; t++) begin
      r    = rand_bits(2);
      size = (r[1:0] == 2'd3) ? size_word : r[1:0]; // code 3 is unused
      addr = rand_bits(6);                          // 64-byte window
      r    = rand_bits(1);
      we   = r[0];
      if (t < num_aligned) begin
        we = 1'b0;
        if (size == size_word) addr[1:0] = 2'b00;
        if (size == size_half) addr[0] = 1'b0;
      end
      r = rand_bits(1);
      run_access(we, addr, size, rand_bits(32), r[0]);
    end
    $display("errors: data %0d addr %0d be %0d flag %0d timeout %0d",
             n_data_err, n_addr_err, n_be_err, n_flag_err, n_timeout);
    if (n_data_err + n_addr_err + n_be_err + n_flag_err + n_timeout == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : lsu_tb

`default_nettype wire

//--- src.f
verilog/lsu_bus_pkg.sv
verilog/lsu_access_pkg.sv
verilog/lsu_req_buf.sv
verilog/lsu_bus_seq.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
testbench/lsu_props.sv
testbench/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lsu testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module lsu_tb \
  -f src.f \
  -Mdir obj_dir -o lsu_sim

./obj_dir/lsu_sim 2>&1 | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
